/* common/dl_grid_pkg.sv */
package dl_grid_pkg;

    // ----------------------------------------------------------------------
    // widths that carry a meaning on the grid side
    // ----------------------------------------------------------------------
    typedef logic [3:0]   re_idx_t;
    typedef logic [8:0]   prb_idx_t;
    typedef logic [3:0]   sym_idx_t;
    typedef logic [7:0]   slot_idx_t;
    typedef logic [31:0]  sample_addr_t;
    // four antennas packed side by side
    typedef logic [127:0] sample_t;
    typedef logic [31:0]  lane_t;
    // high nibble group, low nibble antenna
    typedef logic [7:0]   ant_info_t;
    typedef logic [10:0]  frame_cnt_t;

    // ----------------------------------------------------------------------
    // grid dimensions
    // ----------------------------------------------------------------------
    localparam logic [3:0] RE_NUM  = 4'd12;
    localparam int PRB_NUM         = 132;
    localparam int SYM_NUM         = 14;

    // idle cycles ahead of the active window
    localparam int INIT_NUM        = 1;

    // beats in one burst and cycles in one burst period
    localparam int BURST_LEN       = PRB_NUM * RE_NUM;
    localparam int FRAME_LEN       = BURST_LEN + 2;

    // prbs per packet
    localparam int PKT_PRB         = 4;

endpackage

/* common/iq_tx_pkg.sv */
package iq_tx_pkg;

    // ----------------------------------------------------------------------
    // pacer counters and chip number
    // ----------------------------------------------------------------------
    typedef logic [6:0] iq_cnt_t;
    typedef logic [6:0] start_cnt_t;
    typedef logic [8:0] chip_num_t;

    // cycles after reset before the first period starts
    localparam int IQ_START_DELAY   = 100;
    // cycles between enable pulses
    localparam int IQ_PERIOD        = 96;
    // wraps to 0 on the first pulse
    localparam chip_num_t CHIP_INIT = 9'd511;

endpackage

/* hw/dl_grid/re_grid_counter.sv */
`timescale 1ns/1ps

module re_grid_counter
    import dl_grid_pkg::*;
(
    input  logic      sys_clk_368_64,
    input  logic      sys_rst_491_52,
    output logic      o_beat,
    output re_idx_t   o_re_idx,
    output prb_idx_t  o_prb_idx,
    output sym_idx_t  o_sym_idx,
    output slot_idx_t o_slot_idx,
    output logic      o_group
);

    // position within the burst period
    frame_cnt_t frame_cnt;
    // window decode on the counter value
    logic       in_window;
    // last re of the last prb
    logic       last_beat;

    // ----------------------------------------------------------------------
    // frame counter and active window
    // ----------------------------------------------------------------------
    assign in_window = (frame_cnt >= frame_cnt_t'(INIT_NUM)) &&
                       (frame_cnt <  frame_cnt_t'(INIT_NUM + BURST_LEN));

    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            frame_cnt <= '0;
            o_beat    <= 1'b0;
        end
        else
        begin
            // wraps after FRAME_LEN cycles
            if (frame_cnt == frame_cnt_t'(FRAME_LEN - 1))
                frame_cnt <= '0;
            else
                frame_cnt <= frame_cnt + 1'b1;
            o_beat <= in_window;
        end
    end

    // ----------------------------------------------------------------------
    // re / prb indices
    // ----------------------------------------------------------------------
    assign last_beat = o_beat && (o_re_idx == re_idx_t'(RE_NUM - 1)) &&
                       (o_prb_idx == prb_idx_t'(PRB_NUM - 1));

    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            o_re_idx  <= '0;
            o_prb_idx <= '0;
        end
        else if (o_beat)
        begin
            // step re every beat, prb on re wrap
            if (o_re_idx == re_idx_t'(RE_NUM - 1))
            begin
                o_re_idx <= '0;
                if (o_prb_idx == prb_idx_t'(PRB_NUM - 1))
                    o_prb_idx <= '0;
                else
                    o_prb_idx <= o_prb_idx + 1'b1;
            end
            else
                o_re_idx <= o_re_idx + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // antenna group, symbol and slot
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            o_group    <= 1'b0;
            o_sym_idx  <= '0;
            o_slot_idx <= '0;
        end
        else if (last_beat)
        begin
            // flip in the gap so the next burst starts on the other group
            o_group <= ~o_group;
            // both groups share a symbol, so step only after group 1
            if (o_group)
            begin
                if (o_sym_idx == sym_idx_t'(SYM_NUM - 1))
                begin
                    o_sym_idx  <= '0;
                    o_slot_idx <= o_slot_idx + 1'b1;
                end
                else
                    o_sym_idx <= o_sym_idx + 1'b1;
            end
        end
    end

endmodule

/* hw/dl_grid/re_burst_framer.sv */
`timescale 1ns/1ps

module re_burst_framer
    import dl_grid_pkg::*;
(
    input  logic         sys_clk_368_64,
    input  logic         sys_rst_491_52,
    input  logic         i_beat,
    input  re_idx_t      i_re_idx,
    input  prb_idx_t     i_prb_idx,
    input  sym_idx_t     i_sym_idx,
    input  slot_idx_t    i_slot_idx,
    input  logic         i_group,
    output logic         o_sample_rd,
    output sample_addr_t o_sample_addr,
    input  sample_t      i_sample_data,
    output logic         o_re_valid,
    output logic         o_re_sop,
    output logic         o_re_eop,
    output lane_t        o_ant_lane0,
    output lane_t        o_ant_lane1,
    output lane_t        o_ant_lane2,
    output lane_t        o_ant_lane3,
    output ant_info_t    o_ant_info0,
    output ant_info_t    o_ant_info1,
    output ant_info_t    o_ant_info2,
    output ant_info_t    o_ant_info3,
    output prb_idx_t     o_prb_idx,
    output sym_idx_t     o_sym_idx,
    output slot_idx_t    o_slot_idx
);

    // first stage, lines up with the returned sample
    logic      valid_d1;
    logic      sop_d1;
    logic      eop_d1;
    logic      group_d1;
    prb_idx_t  prb_d1;
    sym_idx_t  sym_d1;
    slot_idx_t slot_d1;
    // second stage payload
    lane_t     lane_q [4];
    ant_info_t info_q [4];

    // ----------------------------------------------------------------------
    // sample read
    // ----------------------------------------------------------------------
    // one read per beat, store answers next cycle
    assign o_sample_rd = i_beat;

    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
            o_sample_addr <= '0;
        else if (i_beat)
            o_sample_addr <= o_sample_addr + 1'b1;
    end

    // ----------------------------------------------------------------------
    // flag pipeline, two stages to meet the data
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            valid_d1   <= 1'b0;
            sop_d1     <= 1'b0;
            eop_d1     <= 1'b0;
            o_re_valid <= 1'b0;
            o_re_sop   <= 1'b0;
            o_re_eop   <= 1'b0;
        end
        else
        begin
            valid_d1 <= i_beat;
            // packet opens on re 0 of every fourth prb
            sop_d1   <= i_beat && (i_re_idx == '0) &&
                        (i_prb_idx % prb_idx_t'(PKT_PRB) == '0);
            // and closes on re 11 of the fourth prb
            eop_d1   <= i_beat && (i_re_idx == re_idx_t'(RE_NUM - 1)) &&
                        (i_prb_idx % prb_idx_t'(PKT_PRB) == prb_idx_t'(PKT_PRB - 1));
            o_re_valid <= valid_d1;
            o_re_sop   <= sop_d1;
            o_re_eop   <= eop_d1;
        end
    end

    // indices and group ride along
    always_ff @(posedge sys_clk_368_64)
    begin
        group_d1   <= i_group;
        prb_d1     <= i_prb_idx;
        sym_d1     <= i_sym_idx;
        slot_d1    <= i_slot_idx;
        o_prb_idx  <= prb_d1;
        o_sym_idx  <= sym_d1;
        o_slot_idx <= slot_d1;
    end

    // ----------------------------------------------------------------------
    // lane split and antenna tags
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        for (int n = 0; n < 4; n++)
        begin
            lane_q[n] <= i_sample_data[32*n +: 32];
            // group 0 even antennas, group 1 odd
            info_q[n] <= {3'b000, group_d1, 1'b0, 2'(n), group_d1};
        end
    end

    assign o_ant_lane0 = lane_q[0];
    assign o_ant_lane1 = lane_q[1];
    assign o_ant_lane2 = lane_q[2];
    assign o_ant_lane3 = lane_q[3];
    assign o_ant_info0 = info_q[0];
    assign o_ant_info1 = info_q[1];
    assign o_ant_info2 = info_q[2];
    assign o_ant_info3 = info_q[3];

endmodule

/* hw/iq_tx_pacer.sv */
`timescale 1ns/1ps

module iq_tx_pacer
    import iq_tx_pkg::*;
(
    input  logic      sys_clk_368_64,
    input  logic      sys_rst_491_52,
    output logic      o_iq_tx_enable,
    output chip_num_t o_chip_num
);

    // counts up once after reset, then holds
    start_cnt_t start_cnt;
    // position within the pulse period
    iq_cnt_t    iq_cnt;
    logic       started;
    logic       period_end;

    assign started    = (start_cnt == start_cnt_t'(IQ_START_DELAY));
    assign period_end = (iq_cnt == iq_cnt_t'(IQ_PERIOD - 1));

    // ----------------------------------------------------------------------
    // start delay and period counter
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            start_cnt <= '0;
            iq_cnt    <= '0;
        end
        else
        begin
            if (!started)
                start_cnt <= start_cnt + 1'b1;
            // period runs only once the delay has expired
            if (!started || period_end)
                iq_cnt <= '0;
            else
                iq_cnt <= iq_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // enable pulse and chip number
    // ----------------------------------------------------------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            o_iq_tx_enable <= 1'b0;
            o_chip_num     <= CHIP_INIT;
        end
        else
        begin
            // one cycle wide, after the last count of the period
            o_iq_tx_enable <= period_end;
            if (period_end)
                o_chip_num <= o_chip_num + 1'b1;
        end
    end

endmodule

/* hw/dl_stim_top.sv */
`timescale 1ns/1ps

module dl_stim_top
    import dl_grid_pkg::*;
    import iq_tx_pkg::*;
(
    input  logic         sys_clk_368_64,
    input  logic         sys_rst_491_52,
    // sample store port
    output logic         o_sample_rd,
    output sample_addr_t o_sample_addr,
    input  sample_t      i_sample_data,
    // re stream
    output logic         o_re_valid,
    output logic         o_re_sop,
    output logic         o_re_eop,
    output lane_t        o_ant_lane0,
    output lane_t        o_ant_lane1,
    output lane_t        o_ant_lane2,
    output lane_t        o_ant_lane3,
    output ant_info_t    o_ant_info0,
    output ant_info_t    o_ant_info1,
    output ant_info_t    o_ant_info2,
    output ant_info_t    o_ant_info3,
    output prb_idx_t     o_prb_idx,
    output sym_idx_t     o_sym_idx,
    output slot_idx_t    o_slot_idx,
    // iq pacing
    output logic         o_iq_tx_enable,
    output chip_num_t    o_chip_num
);

    // ----------------------------------------------------------------------
    // grid position from counter to framer
    // ----------------------------------------------------------------------
    logic      beat;
    re_idx_t   re_idx;
    prb_idx_t  prb_idx;
    sym_idx_t  sym_idx;
    slot_idx_t slot_idx;
    logic      group;

    re_grid_counter u_re_grid_counter (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .o_beat         (beat),
        .o_re_idx       (re_idx),
        .o_prb_idx      (prb_idx),
        .o_sym_idx      (sym_idx),
        .o_slot_idx     (slot_idx),
        .o_group        (group)
    );

    // read strobe leads o_re_valid by two cycles
    re_burst_framer u_re_burst_framer (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .i_beat         (beat),
        .i_re_idx       (re_idx),
        .i_prb_idx      (prb_idx),
        .i_sym_idx      (sym_idx),
        .i_slot_idx     (slot_idx),
        .i_group        (group),
        .o_sample_rd    (o_sample_rd),
        .o_sample_addr  (o_sample_addr),
        .i_sample_data  (i_sample_data),
        .o_re_valid     (o_re_valid),
        .o_re_sop       (o_re_sop),
        .o_re_eop       (o_re_eop),
        .o_ant_lane0    (o_ant_lane0),
        .o_ant_lane1    (o_ant_lane1),
        .o_ant_lane2    (o_ant_lane2),
        .o_ant_lane3    (o_ant_lane3),
        .o_ant_info0    (o_ant_info0),
        .o_ant_info1    (o_ant_info1),
        .o_ant_info2    (o_ant_info2),
        .o_ant_info3    (o_ant_info3),
        .o_prb_idx      (o_prb_idx),
        .o_sym_idx      (o_sym_idx),
        .o_slot_idx     (o_slot_idx)
    );

    // independent of the grid
    iq_tx_pacer u_iq_tx_pacer (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .o_iq_tx_enable (o_iq_tx_enable),
        .o_chip_num     (o_chip_num)
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic o_clk,
    output logic o_rst
);

    // half of the 20 ns period
    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 10;

    initial
    begin
        o_clk = 1'b0;
        forever
            #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // reset high from time zero, dropped on a rising edge
    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* test/dl_stim_props.sv */
`timescale 1ns/1ps

module dl_stim_props
(
    input logic sys_clk_368_64,
    input logic sys_rst_491_52,
    input logic i_sample_rd,
    input logic i_re_valid,
    input logic i_re_sop,
    input logic i_re_eop,
    input logic i_iq_tx_enable
);

    // valid one cycle back
    logic valid_q;
    // set once a burst has ended, so the gap before it is known
    logic seen_fall;

    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            valid_q   <= 1'b0;
            seen_fall <= 1'b0;
        end
        else
        begin
            valid_q <= i_re_valid;
            if (valid_q && !i_re_valid)
                seen_fall <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // framing and pulse shape
    // ----------------------------------------------------------------------
    a_sop_in_valid: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_re_sop |-> i_re_valid)
        else $error("sop outside a valid beat");

    a_eop_in_valid: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_re_eop |-> i_re_valid)
        else $error("eop outside a valid beat");

    // read strobe leads valid by two cycles
    a_rd_to_valid: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_re_valid == $past(i_sample_rd, 2))
        else $error("valid does not trail the read strobe by two cycles");

    a_enable_single: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_enable |=> !i_iq_tx_enable)
        else $error("enable high on two cycles in a row");

    // two low cycles between bursts
    a_gap_two: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        (seen_fall && $rose(i_re_valid)) |-> (!$past(i_re_valid, 2) && $past(i_re_valid, 3)))
        else $error("gap between bursts is not two cycles");

endmodule

bind dl_stim_top dl_stim_props u_dl_stim_props (
    .sys_clk_368_64 (sys_clk_368_64),
    .sys_rst_491_52 (sys_rst_491_52),
    .i_sample_rd    (o_sample_rd),
    .i_re_valid     (o_re_valid),
    .i_re_sop       (o_re_sop),
    .i_re_eop       (o_re_eop),
    .i_iq_tx_enable (o_iq_tx_enable)
);

/* test/tb_dl_stim.sv */
`timescale 1ns/1ps

module tb_dl_stim
    import dl_grid_pkg::*;
    import iq_tx_pkg::*;
();

    localparam int SEED           = 35;
    localparam int LAST_BURST     = 29;
    localparam int TIMEOUT_CYCLES = (LAST_BURST + 3) * FRAME_LEN + IQ_START_DELAY + 200;
    localparam int BEATS_PER_PRB  = int'(RE_NUM);
    localparam int BEATS_PER_PKT  = BEATS_PER_PRB * PKT_PRB;
    localparam int PKTS_PER_BURST = PRB_NUM / PKT_PRB;
    // pulses expected by the time the last burst closes, with margin
    localparam int MIN_PULSES     =
        ((LAST_BURST + 1) * FRAME_LEN - 2 * IQ_START_DELAY) / IQ_PERIOD - 2;
    localparam int NUM_ROWS       = 7;

    // ----------------------------------------------------------------------
    // checkpoint table with name, burst, group, symbol and slot per row
    // ----------------------------------------------------------------------
    string     row_name  [NUM_ROWS] = '{"burst 0", "burst 1", "burst 2", "burst 3",
                                        "burst 27", "burst 28", "burst 29"};
    int        row_burst [NUM_ROWS] = '{0, 1, 2, 3, 27, 28, 29};
    logic      row_group [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    sym_idx_t  row_sym   [NUM_ROWS] = '{4'd0, 4'd0, 4'd1, 4'd1, 4'd13, 4'd0, 4'd0};
    slot_idx_t row_slot  [NUM_ROWS] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1, 8'd1};

    logic         sys_clk_368_64;
    logic         sys_rst_491_52;
    logic         o_sample_rd;
    sample_addr_t o_sample_addr;
    sample_t      sample_data;
    logic         o_re_valid;
    logic         o_re_sop;
    logic         o_re_eop;
    lane_t        o_ant_lane0;
    lane_t        o_ant_lane1;
    lane_t        o_ant_lane2;
    lane_t        o_ant_lane3;
    ant_info_t    o_ant_info0;
    ant_info_t    o_ant_info1;
    ant_info_t    o_ant_info2;
    ant_info_t    o_ant_info3;
    prb_idx_t     o_prb_idx;
    sym_idx_t     o_sym_idx;
    slot_idx_t    o_slot_idx;
    logic         o_iq_tx_enable;
    chip_num_t    o_chip_num;

    // random words mixed into the store contents
    lane_t        key [4];
    // stream monitor state
    logic         in_burst    = 1'b0;
    int           burst_beat  = 0;
    int           global_beat = 0;
    int           bursts_done = 0;
    int           gap_len     = 0;
    int           sop_cnt     = 0;
    int           eop_cnt     = 0;
    // checkpoint walker state
    logic         last_valid     = 1'b0;
    int           bursts_started = 0;
    // pacer monitor state
    int           rel_cycles  = 0;
    int           last_pulse  = 0;
    int           pulses_seen = 0;
    int           timeout_cnt = 0;
    logic         run_passed  = 1'b0;
    logic         run_failed  = 1'b0;

    tb_clk_gen u_clk_gen (
        .o_clk (sys_clk_368_64),
        .o_rst (sys_rst_491_52)
    );

    dl_stim_top uut (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .o_sample_rd    (o_sample_rd),
        .o_sample_addr  (o_sample_addr),
        .i_sample_data  (sample_data),
        .o_re_valid     (o_re_valid),
        .o_re_sop       (o_re_sop),
        .o_re_eop       (o_re_eop),
        .o_ant_lane0    (o_ant_lane0),
        .o_ant_lane1    (o_ant_lane1),
        .o_ant_lane2    (o_ant_lane2),
        .o_ant_lane3    (o_ant_lane3),
        .o_ant_info0    (o_ant_info0),
        .o_ant_info1    (o_ant_info1),
        .o_ant_info2    (o_ant_info2),
        .o_ant_info3    (o_ant_info3),
        .o_prb_idx      (o_prb_idx),
        .o_sym_idx      (o_sym_idx),
        .o_slot_idx     (o_slot_idx),
        .o_iq_tx_enable (o_iq_tx_enable),
        .o_chip_num     (o_chip_num)
    );

    // ----------------------------------------------------------------------
    // error reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        begin
            run_failed = 1'b1;
            $display("%s", msg);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_lane(input string name, input lane_t exp, input lane_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_info(input string name, input ant_info_t exp, input ant_info_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_prb(input string name, input prb_idx_t exp, input prb_idx_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_sym(input string name, input sym_idx_t exp, input sym_idx_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_slot(input string name, input slot_idx_t exp, input slot_idx_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_chip(input string name, input chip_num_t exp, input chip_num_t act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    endtask

    // ----------------------------------------------------------------------
    // sample store model
    // ----------------------------------------------------------------------
    // mix of the full address and the key, per lane
    function automatic sample_t model_sample(input sample_addr_t addr);
        sample_t s;
        begin
            for (int n = 0; n < 4; n++)
                s[32*n +: 32] = key[n] ^ (addr * 32'h9e37_79b1) ^
                                ({addr[15:0], addr[31:16]} + 32'(n));
            return s;
        end
    endfunction

    // answers one cycle after the strobe
    always @(posedge sys_clk_368_64)
    begin
        if (o_sample_rd === 1'b1)
            sample_data <= model_sample(o_sample_addr);
    end

    // ----------------------------------------------------------------------
    // per-beat stream monitor
    // ----------------------------------------------------------------------
    task automatic check_beat();
        sample_t exp_sample;
        begin
            exp_sample = model_sample(sample_addr_t'(global_beat));
            check_lane("lane 0", exp_sample[31:0], o_ant_lane0);
            check_lane("lane 1", exp_sample[63:32], o_ant_lane1);
            check_lane("lane 2", exp_sample[95:64], o_ant_lane2);
            check_lane("lane 3", exp_sample[127:96], o_ant_lane3);
            check_prb("prb index", prb_idx_t'(burst_beat / BEATS_PER_PRB), o_prb_idx);
            // packet of four prbs
            check_flag("sop", (burst_beat % BEATS_PER_PKT) == 0, o_re_sop);
            check_flag("eop", (burst_beat % BEATS_PER_PKT) == BEATS_PER_PKT - 1, o_re_eop);
        end
    endtask

    always @(negedge sys_clk_368_64)
    begin
        if (!sys_rst_491_52)
        begin
            if (o_re_valid === 1'b1)
            begin
                if (!in_burst)
                begin
                    // no gap to measure ahead of the first burst
                    if (bursts_done > 0)
                        check_count("gap length", 2, gap_len);
                    in_burst   = 1'b1;
                    burst_beat = 0;
                    sop_cnt    = 0;
                    eop_cnt    = 0;
                end
                check_beat();
                if (o_re_sop)
                    sop_cnt++;
                if (o_re_eop)
                    eop_cnt++;
                burst_beat++;
                global_beat++;
            end
            else
            begin
                if (in_burst)
                begin
                    check_count("beats per burst", BURST_LEN, burst_beat);
                    check_count("sop per burst", PKTS_PER_BURST, sop_cnt);
                    check_count("eop per burst", PKTS_PER_BURST, eop_cnt);
                    in_burst = 1'b0;
                    gap_len  = 0;
                    bursts_done++;
                end
                gap_len++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // pacer monitor
    // ----------------------------------------------------------------------
    always @(negedge sys_clk_368_64)
    begin
        if (!sys_rst_491_52)
        begin
            rel_cycles++;
            if (o_iq_tx_enable === 1'b1)
            begin
                if (pulses_seen == 0 && rel_cycles <= IQ_START_DELAY)
                    stop_on_error("enable pulse came before the start delay expired");
                else if (pulses_seen > 0)
                    check_count("enable spacing", IQ_PERIOD, rel_cycles - last_pulse);
                // first pulse carries chip 0
                check_chip("chip number", chip_num_t'(pulses_seen), o_chip_num);
                last_pulse = rel_cycles;
                pulses_seen++;
            end
        end
    end

    // hard stop
    always @(posedge sys_clk_368_64)
    begin
        timeout_cnt++;
        if (timeout_cnt > TIMEOUT_CYCLES)
            stop_on_error($sformatf("TIMEOUT: run did not finish within %0d cycles",
                                    TIMEOUT_CYCLES));
    end

    // ----------------------------------------------------------------------
    // checkpoint walk
    // ----------------------------------------------------------------------
    // parks on the first beat of the wanted burst
    task automatic skip_to_burst(input int target);
        logic found;
        begin
            found = 1'b0;
            while (!found)
            begin
                @(negedge sys_clk_368_64);
                if (o_re_valid === 1'b1 && !last_valid)
                begin
                    bursts_started++;
                    found = (bursts_started == target + 1);
                end
                last_valid = (o_re_valid === 1'b1);
            end
        end
    endtask

    task automatic check_row(input int i);
        ant_info_t exp_info [4];
        int        grp;
        begin
            grp = int'(row_group[i]);
            // group in the high nibble, antenna 2n+group in the low one
            for (int n = 0; n < 4; n++)
                exp_info[n] = ant_info_t'(16 * grp + 2 * n + grp);
            check_info({row_name[i], " info 0"}, exp_info[0], o_ant_info0);
            check_info({row_name[i], " info 1"}, exp_info[1], o_ant_info1);
            check_info({row_name[i], " info 2"}, exp_info[2], o_ant_info2);
            check_info({row_name[i], " info 3"}, exp_info[3], o_ant_info3);
            check_sym({row_name[i], " symbol"}, row_sym[i], o_sym_idx);
            check_slot({row_name[i], " slot"}, row_slot[i], o_slot_idx);
        end
    endtask

    initial
    begin
        sample_data = '0;
        void'($urandom(SEED));
        for (int n = 0; n < 4; n++)
            key[n] = $urandom();

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            skip_to_burst(row_burst[i]);
            check_row(i);
        end

        // let the monitor close the last burst
        while (bursts_done <= LAST_BURST)
            @(posedge sys_clk_368_64);

        if (pulses_seen >= MIN_PULSES)
        begin
            run_passed = 1'b1;
            $display("Simulation passed");
            $finish;
        end
        else
            stop_on_error($sformatf("only %0d enable pulses seen, at least %0d expected",
                                    pulses_seen, MIN_PULSES));
    end

    final
    begin
        if (!run_passed && !run_failed)
            $display("Simulation failed");
    end

endmodule

/* sources.f */
common/dl_grid_pkg.sv
common/iq_tx_pkg.sv
hw/dl_grid/re_grid_counter.sv
hw/dl_grid/re_burst_framer.sv
hw/iq_tx_pacer.sv
hw/dl_stim_top.sv
test/tb_clk_gen.sv
test/dl_stim_props.sv
test/tb_dl_stim.sv

/* Makefile */
# Verilator flow for the downlink stimulus generator

VERILATOR ?= verilator
TOP       ?= tb_dl_stim
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
